/* hw/cache_geom_pkg.sv */
package cache_geom_pkg;

	// processor side
	localparam int ADDR_W = 16;	// word address, not byte address
	localparam int WORD_W = 16;

	// line layout, word 0 sits in the low bits of a line
	localparam int LINE_WORDS = 4;
	localparam int LINE_W = LINE_WORDS * WORD_W;
	localparam int OFFSET_W = $clog2(LINE_WORDS);

	// two ways of SETS entries each
	localparam int SET_W = 5;
	localparam int SETS = 1 << SET_W;
	localparam int TAG_W = ADDR_W - SET_W - OFFSET_W;

	// main memory holds whole lines
	localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;
	localparam int MEM_LINES = 1 << LINE_ADDR_W;
	localparam int MEM_LATENCY = 4;	// cycles from request to ack
	localparam int MEM_CNT_W = $clog2(MEM_LATENCY);

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [SET_W-1:0] set_idx_t;
	typedef logic [OFFSET_W-1:0] word_off_t;
	typedef logic [LINE_W-1:0] line_t;
	typedef logic [LINE_ADDR_W-1:0] line_addr_t;

	// one way entry as stored and read back
	typedef struct packed {
		logic valid;
		logic dirty;	// line differs from main memory
		tag_t tag;
		line_t line;
	} cache_entry_t;

endpackage

/* hw/cache_bus_pkg.sv */
package cache_bus_pkg;

	// word request from the processor, wishbone classic
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [cache_geom_pkg::ADDR_W-1:0] adr;
		logic [cache_geom_pkg::WORD_W-1:0] dat;	// write data
	} cpu_req_t;

	// ack is a one cycle pulse, dat valid with it on reads
	typedef struct packed {
		logic ack;
		logic [cache_geom_pkg::WORD_W-1:0] dat;
	} cpu_rsp_t;

	// line request to main memory
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		cache_geom_pkg::line_addr_t adr;	// word address without offset
		cache_geom_pkg::line_t dat;
	} mem_req_t;

	typedef struct packed {
		logic ack;
		cache_geom_pkg::line_t dat;
	} mem_rsp_t;

endpackage

/* hw/dcache_store.sv */
`timescale 1ns/1ps

module dcache_store (
	input  logic                        clk,
	input  logic                        rst,
	input  cache_geom_pkg::set_idx_t     i_set,
	input  logic [1:0]                  i_way_we,
	input  cache_geom_pkg::cache_entry_t i_wr_entry,
	input  logic                        i_lru_we,
	input  logic                        i_used_way,
	output cache_geom_pkg::cache_entry_t o_entry0,
	output cache_geom_pkg::cache_entry_t o_entry1,
	output logic                        o_mru
);
	import cache_geom_pkg::*;

	cache_entry_t rd_entry [2];	// registered read of both ways
	logic [SETS-1:0] mru_q;	// way used last, per set

	for (genvar w = 0; w < 2; w++) begin : g_way
		cache_entry_t mem [SETS];
		cache_entry_t entry_q;
		logic [SETS-1:0] valid_q;
		logic vld_q;

		// data array, read returns the old entry on a same-set write
		always_ff @(posedge clk) begin
			if (i_way_we[w]) begin
				mem[i_set] <= i_wr_entry;
			end
			entry_q <= mem[i_set];
		end

		// valid bits live apart so reset can clear them
		always_ff @(posedge clk) begin
			if (rst) begin
				valid_q <= '0;
				vld_q <= 1'b0;
			end else begin
				if (i_way_we[w]) begin
					valid_q[i_set] <= i_wr_entry.valid;
				end
				vld_q <= valid_q[i_set];
			end
		end

		assign rd_entry[w] = '{
			valid: vld_q,
			dirty: entry_q.dirty,
			tag:   entry_q.tag,
			line:  entry_q.line
		};
	end

	// lru, one bit per set is enough for two ways
	always_ff @(posedge clk) begin
		if (rst) begin
			mru_q <= '0;
			o_mru <= 1'b0;
		end else begin
			if (i_lru_we) begin
				mru_q[i_set] <= i_used_way;
			end
			o_mru <= mru_q[i_set];	// same timing as the way reads
		end
	end

	assign o_entry0 = rd_entry[0];
	assign o_entry1 = rd_entry[1];

	// controller must never fill both ways of a set at once
	a_one_way: assert property (@(posedge clk) disable iff (rst)
		$onehot0(i_way_we))
		else $error("both way write enables high");

endmodule

/* hw/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
	input  logic                        clk,
	input  logic                        rst,
	input  cache_bus_pkg::cpu_req_t      i_cpu_req,
	output cache_bus_pkg::cpu_rsp_t      o_cpu_rsp,
	output cache_bus_pkg::mem_req_t      o_mem_req,
	input  cache_bus_pkg::mem_rsp_t      i_mem_rsp,
	output cache_geom_pkg::set_idx_t     o_set,
	output logic [1:0]                  o_way_we,
	output cache_geom_pkg::cache_entry_t o_wr_entry,
	output logic                        o_lru_we,
	output logic                        o_used_way,
	input  cache_geom_pkg::cache_entry_t i_entry0,
	input  cache_geom_pkg::cache_entry_t i_entry1,
	input  logic                        i_mru
);
	import cache_geom_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_writeback,
		st_refill,
		st_reread,
		st_rest
	} state_t;

	state_t state, state_nxt;

	// request fields, captured while idle
	tag_t tag_q;
	set_idx_t set_q;
	word_off_t off_q;
	logic we_q;
	logic [WORD_W-1:0] wdat_q;

	logic victim_q;	// way picked on the miss
	logic ack_q;
	logic [WORD_W-1:0] rdat_q;

	logic hit0, hit1, hit, hit_way;
	logic victim_way, vict_sel;
	cache_entry_t hit_entry, vict_entry;
	line_t base_line, new_line;

	// put one word into a line
	function automatic line_t merge_word(line_t line, word_off_t off, logic [WORD_W-1:0] word);
		line_t merged;
		merged = line;
		merged[off*WORD_W +: WORD_W] = word;
		return merged;
	endfunction

	assign hit0 = i_entry0.valid && (i_entry0.tag == tag_q);
	assign hit1 = i_entry1.valid && (i_entry1.tag == tag_q);
	assign hit = hit0 || hit1;
	assign hit_way = !hit0;
	assign hit_entry = hit0 ? i_entry0 : i_entry1;

	// empty way 0, then empty way 1, else the older one
	assign victim_way = !i_entry0.valid ? 1'b0 :
		!i_entry1.valid ? 1'b1 : !i_mru;
	assign vict_sel = (state == st_lookup) ? victim_way : victim_q;
	assign vict_entry = vict_sel ? i_entry1 : i_entry0;

	// refill takes the fetched line, a write hit the cached one
	assign base_line = (state == st_refill) ? i_mem_rsp.dat : hit_entry.line;
	assign new_line = we_q ? merge_word(base_line, off_q, wdat_q) : base_line;

	// store reads the incoming set while idle, the held set otherwise
	assign o_set = (state == st_idle) ? i_cpu_req.adr[OFFSET_W +: SET_W] : set_q;
	assign o_wr_entry = '{valid: 1'b1, dirty: we_q, tag: tag_q, line: new_line};
	assign o_lru_we = (state == st_lookup) && hit;
	assign o_used_way = hit_way;

	always_comb begin
		state_nxt = state;
		o_way_we = 2'b00;
		o_mem_req = '{
			cyc: 1'b0,
			stb: 1'b0,
			we:  1'b0,
			adr: {tag_q, set_q},
			dat: vict_entry.line
		};
		case (state)
			st_idle: begin
				if (i_cpu_req.cyc && i_cpu_req.stb) begin
					state_nxt = st_lookup;
				end
			end
			st_lookup: begin
				if (hit) begin
					o_way_we[hit_way] = we_q;	// write hit updates in place
					state_nxt = st_rest;
				end else if (vict_entry.valid && vict_entry.dirty) begin
					state_nxt = st_writeback;
				end else begin
					state_nxt = st_refill;
				end
			end
			st_writeback: begin
				o_mem_req.cyc = 1'b1;
				o_mem_req.stb = 1'b1;
				o_mem_req.we = 1'b1;
				o_mem_req.adr = {vict_entry.tag, set_q};	// old owner of the line
				if (i_mem_rsp.ack) begin
					state_nxt = st_refill;
				end
			end
			st_refill: begin
				o_mem_req.cyc = 1'b1;
				o_mem_req.stb = 1'b1;
				if (i_mem_rsp.ack) begin
					o_way_we[victim_q] = 1'b1;
					state_nxt = st_reread;
				end
			end
			st_reread: state_nxt = st_lookup;	// let the new line reach the read port
			st_rest: state_nxt = st_idle;	// keeps acks apart
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			ack_q <= 1'b0;
		end else begin
			state <= state_nxt;
			ack_q <= (state == st_lookup) && hit;
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle) begin
			tag_q <= i_cpu_req.adr[ADDR_W-1 -: TAG_W];
			set_q <= i_cpu_req.adr[OFFSET_W +: SET_W];
			off_q <= i_cpu_req.adr[OFFSET_W-1:0];
			we_q <= i_cpu_req.we;
			wdat_q <= i_cpu_req.dat;
		end
		if (state == st_lookup) begin
			rdat_q <= hit_entry.line[off_q*WORD_W +: WORD_W];
			victim_q <= victim_way;
		end
	end

	assign o_cpu_rsp = '{ack: ack_q, dat: rdat_q};

	a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
		o_cpu_rsp.ack |=> !o_cpu_rsp.ack)
		else $error("cpu ack high in two consecutive cycles");

	// wishbone master holds its request until the slave acks
	a_mem_hold: assert property (@(posedge clk) disable iff (rst)
		o_mem_req.cyc && !i_mem_rsp.ack |=> $stable(o_mem_req))
		else $error("memory request changed before ack");

endmodule

/* hw/line_mem.sv */
`timescale 1ns/1ps

module line_mem (
	input  logic                   clk,
	input  logic                   rst,
	input  cache_bus_pkg::mem_req_t i_mem_req,
	output cache_bus_pkg::mem_rsp_t o_mem_rsp
);
	import cache_geom_pkg::*;

	typedef enum logic {
		mem_wait,
		mem_count
	} mem_state_t;

	localparam logic [MEM_CNT_W-1:0] CNT_LAST = MEM_CNT_W'(MEM_LATENCY - 1);

	mem_state_t state;
	logic [MEM_CNT_W-1:0] cnt;
	line_t mem [MEM_LINES];
	line_t rd_q;
	logic req;
	logic ack;

	// every word starts out holding its own word address
	initial begin
		for (int la = 0; la < MEM_LINES; la++) begin
			for (int w = 0; w < LINE_WORDS; w++) begin
				mem[la][w*WORD_W +: WORD_W] = WORD_W'(la * LINE_WORDS + w);
			end
		end
	end

	assign req = i_mem_req.cyc && i_mem_req.stb;

	// delay counter, starts when a request is first seen
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mem_wait;
			cnt <= '0;
		end else begin
			case (state)
				mem_wait: begin
					if (req) begin
						state <= mem_count;
						cnt <= '0;
					end
				end
				mem_count: begin
					if (cnt == CNT_LAST) begin
						state <= mem_wait;	// ack cycle ends the access
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= mem_wait;
			endcase
		end
	end

	assign ack = (state == mem_count) && (cnt == CNT_LAST);

	always_ff @(posedge clk) begin
		if (ack && i_mem_req.we) begin
			mem[i_mem_req.adr] <= i_mem_req.dat;
		end
		rd_q <= mem[i_mem_req.adr];	// address is held for the whole count
	end

	assign o_mem_rsp = '{ack: ack, dat: rd_q};

	a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
		ack |-> req)
		else $error("memory ack without an active request");

endmodule

/* hw/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
	input  logic                   clk,
	input  logic                   rst,
	input  cache_bus_pkg::cpu_req_t i_cpu_req,
	output cache_bus_pkg::cpu_rsp_t o_cpu_rsp
);

	cache_bus_pkg::mem_req_t mem_req;
	cache_bus_pkg::mem_rsp_t mem_rsp;
	cache_geom_pkg::set_idx_t set;
	cache_geom_pkg::cache_entry_t wr_entry;
	cache_geom_pkg::cache_entry_t entry0;
	cache_geom_pkg::cache_entry_t entry1;
	logic [1:0] way_we;
	logic lru_we;
	logic used_way;
	logic mru;

	dcache_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.i_cpu_req  (i_cpu_req),
		.o_cpu_rsp  (o_cpu_rsp),
		.o_mem_req  (mem_req),
		.i_mem_rsp  (mem_rsp),
		.o_set      (set),
		.o_way_we   (way_we),
		.o_wr_entry (wr_entry),
		.o_lru_we   (lru_we),
		.o_used_way (used_way),
		.i_entry0   (entry0),
		.i_entry1   (entry1),
		.i_mru      (mru)
	);

	dcache_store u_store (
		.clk        (clk),
		.rst        (rst),
		.i_set      (set),
		.i_way_we   (way_we),
		.i_wr_entry (wr_entry),
		.i_lru_we   (lru_we),
		.i_used_way (used_way),
		.o_entry0   (entry0),
		.o_entry1   (entry1),
		.o_mru      (mru)
	);

	line_mem u_mem (
		.clk       (clk),
		.rst       (rst),
		.i_mem_req (mem_req),
		.o_mem_rsp (mem_rsp)
	);

endmodule

/* verification/dcache_checker.sv */
`timescale 1ns/1ps

module dcache_checker (
	input  logic                   clk,
	input  logic                   rst,
	input  cache_bus_pkg::cpu_req_t i_cpu_req,
	input  cache_bus_pkg::cpu_rsp_t i_cpu_rsp,
	output int                     o_checks,
	output int                     o_data_errors,
	output int                     o_proto_errors
);
	import cache_geom_pkg::*;

	logic [WORD_W-1:0] model [1 << ADDR_W];	// flat word view of memory plus cache
	logic req;
	logic in_req;	// a request is open and not yet acked
	logic fast_q;	// open request repeats the last acked address
	logic prev_ack;
	logic have_last;
	logic [ADDR_W-1:0] last_adr;
	int wait_cnt;

	// memory starts with each word equal to its own address
	initial begin
		for (int a = 0; a < (1 << ADDR_W); a++) begin
			model[a] = WORD_W'(a);
		end
		o_checks = 0;
		o_data_errors = 0;
		o_proto_errors = 0;
	end

	assign req = i_cpu_req.cyc && i_cpu_req.stb;

	always @(posedge clk) begin
		if (rst) begin
			in_req <= 1'b0;
			fast_q <= 1'b0;
			prev_ack <= 1'b0;
			have_last <= 1'b0;
			wait_cnt <= 0;
		end else begin
			if ($isunknown(i_cpu_rsp.ack)) begin
				$display("cpu ack is unknown at %0t", $time);
				o_proto_errors++;
			end else if (i_cpu_rsp.ack) begin
				if (prev_ack) begin
					$display("cpu ack high in two adjacent cycles at %0t", $time);
					o_proto_errors++;
				end
				if (!req) begin
					$display("cpu ack without a request at %0t", $time);
					o_proto_errors++;
				end else begin
					if (i_cpu_req.we) begin
						model[i_cpu_req.adr] <= i_cpu_req.dat;
					end else begin
						o_checks++;
						if (i_cpu_rsp.dat !== model[i_cpu_req.adr]) begin
							$display("mismatch at %0t: read of %h returned %h, expected %h",
								$time, i_cpu_req.adr, i_cpu_rsp.dat, model[i_cpu_req.adr]);
							o_data_errors++;
						end
					end
					// the line is resident, so this one must be a plain hit
					if (fast_q && in_req) begin
						o_checks++;
						if (wait_cnt != 2) begin
							$display("repeat access to %h acked after %0d cycles instead of 2 at %0t",
								i_cpu_req.adr, wait_cnt, $time);
							o_proto_errors++;
						end
					end
					last_adr <= i_cpu_req.adr;
					have_last <= 1'b1;
				end
				in_req <= 1'b0;
			end else if (req) begin
				if (!in_req) begin
					in_req <= 1'b1;
					wait_cnt <= 1;
					fast_q <= have_last && (i_cpu_req.adr == last_adr);
				end else begin
					wait_cnt <= wait_cnt + 1;
				end
			end
			prev_ack <= (i_cpu_rsp.ack === 1'b1);
		end
	end

endmodule

/* verification/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;

	localparam int ACK_TIMEOUT = 100;	// cycles, well above a dirty miss
	localparam int RAND_OPS = 400;
	localparam int RESET_CYCLES = 16;

	logic clk;
	logic rst;
	cpu_req_t cpu_req;
	cpu_rsp_t cpu_rsp;

	integer seed;
	int timeouts;
	logic timed_out;
	logic [ADDR_W-1:0] last_adr;

	int checks;
	int data_errors;
	int proto_errors;
	int total_errors;

	initial clk = 1'b0;
	always #2 clk = ~clk;

	dcache_top UUT (
		.clk       (clk),
		.rst       (rst),
		.i_cpu_req (cpu_req),
		.o_cpu_rsp (cpu_rsp)
	);

	dcache_checker u_checker (
		.clk            (clk),
		.rst            (rst),
		.i_cpu_req      (cpu_req),
		.i_cpu_rsp      (cpu_rsp),
		.o_checks       (checks),
		.o_data_errors  (data_errors),
		.o_proto_errors (proto_errors)
	);

	// four tags over four sets, more tags than ways so lines get evicted
	function automatic logic [ADDR_W-1:0] pool_addr(input logic [1:0] t, input logic [1:0] s,
		input logic [1:0] w);
		tag_t tag;
		set_idx_t set;
		case (t)
			2'd0: tag = 9'h011;
			2'd1: tag = 9'h0a5;
			2'd2: tag = 9'h1f2;
			default: tag = 9'h07c;
		endcase
		case (s)
			2'd0: set = 5'd3;
			2'd1: set = 5'd7;
			2'd2: set = 5'd12;
			default: set = 5'd25;
		endcase
		return {tag, set, w};
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// one wishbone access, held until ack is seen
	task automatic access(input logic we, input logic [ADDR_W-1:0] adr,
		input logic [WORD_W-1:0] dat);
		int cycles;
		logic acked;
		cpu_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		cycles = 0;
		acked = 1'b0;
		while (!acked && cycles < ACK_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			acked = cpu_rsp.ack;
		end
		if (!acked) begin
			$display("timeout: %s of address %h got no ack within %0d cycles",
				we ? "write" : "read", adr, ACK_TIMEOUT);
			timeouts++;
			timed_out = 1'b1;
		end
		@(negedge clk);	// ack cycle closes at the rising edge before this
		cpu_req = '0;
		last_adr = adr;
	endtask

	initial begin
		logic [31:0] r;
		logic [ADDR_W-1:0] adr;
		cpu_req = '0;
		rst = 1'b1;
		seed = 32'ha2d1_f9e6;
		timeouts = 0;
		timed_out = 1'b0;
		last_adr = '0;
		idle_cycles(RESET_CYCLES);
		rst = 1'b0;
		idle_cycles(8);	// bus quiet, no ack may show up here

		// random reads and writes over the pool, some repeats of the last address
		for (int i = 0; i < RAND_OPS && !timed_out; i++) begin
			r = $random(seed);
			if (i > 0 && r[3:2] == 2'b00) begin
				adr = last_adr;
			end else begin
				adr = pool_addr(r[5:4], r[7:6], r[9:8]);
			end
			if (r[13:11] == 3'd0) begin
				idle_cycles(1);
			end
			access(r[10], adr, r[31:16]);
		end

		// read back every word of every pool line
		for (int t = 0; t < 4; t++) begin
			for (int s = 0; s < 4; s++) begin
				for (int w = 0; w < 4; w++) begin
					if (!timed_out) begin
						access(1'b0, pool_addr(t[1:0], s[1:0], w[1:0]), '0);
					end
				end
			end
		end

		idle_cycles(4);
		total_errors = data_errors + proto_errors + timeouts;
		$display("checks %0d, data mismatches %0d, protocol errors %0d, timeouts %0d",
			checks, data_errors, proto_errors, timeouts);
		if (total_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* build.f */
hw/cache_geom_pkg.sv
hw/cache_bus_pkg.sv
hw/dcache_store.sv
hw/dcache_ctrl.sv
hw/line_mem.sv
hw/dcache_top.sv
verification/dcache_checker.sv
verification/tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - hw/cache_geom_pkg.sv
  - hw/cache_bus_pkg.sv
  - hw/dcache_store.sv
  - hw/dcache_ctrl.sv
  - hw/line_mem.sv
  - hw/dcache_top.sv
  - target: simulation
    files:
      - verification/dcache_checker.sv
      - verification/tb_dcache.sv
